/* hw/mem_edge_pkg.sv */
package mem_edge_pkg;

    // ========================================
    // Widths that carry a meaning
    // ========================================

    // Cache-line address, one unit per line
    typedef logic [31:0] cl_addr_t;

    // One line of data as it moves between the AFU, the heap and memory
    typedef logic [63:0] cl_data_t;

    // Request metadata, echoed back unchanged with every read response
    typedef logic [15:0] mdata_t;

    // Beat index inside a packet, or a packet length stored as beats minus one
    typedef logic [1:0] cl_num_t;

    // ========================================
    // Limits
    // ========================================

    // Largest multi-beat write packet
    localparam int MAX_BEATS = 4;

    // Almost-full rises once fewer than this many FIFO slots are free
    localparam int WR_ALMOST_FULL_THRESHOLD = 4;

    // ========================================
    // AFU edge write FSM
    // ========================================

    // Idle between packets, inside a packet, or stalled with no heap slot left
    typedef enum logic [1:0] {
        st_idle,
        st_beats,
        st_wait_slot
    } afu_edge_state_t;

endpackage

/* hw/write_heap.sv */
module write_heap
    import mem_edge_pkg::*;
#(
    parameter int N_ENTRIES = 16,
    localparam int ADDR_BITS = $clog2(N_ENTRIES)
)
(
    input  logic                 clk,

    // Write port, driven by the AFU edge
    input  logic                 wen,
    input  logic [ADDR_BITS-1:0] waddr,
    input  cl_data_t             wdata,

    // Read port, driven by the FIU edge expansion pipeline
    input  logic [ADDR_BITS-1:0] raddr,
    output cl_data_t             rdata
);

    // Storage for every beat of every slot
    // The address is the slot index with the beat number below it
    cl_data_t mem [N_ENTRIES];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // One registered read stage, so data follows raddr by one cycle
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

/* hw/req_fifo.sv */
module req_fifo
    import mem_edge_pkg::*;
#(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES = 6,
    localparam int PTR_BITS = $clog2(N_ENTRIES),
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1)
)
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   enq_en,
    input  logic [N_DATA_BITS-1:0] enq_data,
    output logic                   almost_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic                   deq_en,
    output logic                   not_empty
);

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [CNT_BITS-1:0]    count;

    // The head entry is visible without a read cycle
    assign first = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Leave room for requests already on their way when almost_full rises
    assign almost_full = (N_ENTRIES - int'(count)) < WR_ALMOST_FULL_THRESHOLD;

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Pointers wrap explicitly, so the depth need not be a power of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= (wr_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            if (deq_en)
                rd_ptr <= (rd_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;

            // Simultaneous enq and deq leave the count unchanged
            if (enq_en && !deq_en)
                count <= count + 1'b1;
            else if (deq_en && !enq_en)
                count <= count - 1'b1;
        end
    end

endmodule

/* hw/afu_edge.sv */
module afu_edge
    import mem_edge_pkg::*;
#(
    parameter int N_HEAP_ENTRIES = 4,
    localparam int IDX_BITS = $clog2(N_HEAP_ENTRIES),
    localparam int HEAP_ADDR_BITS = IDX_BITS + $bits(cl_num_t)
)
(
    input  logic                      clk,
    input  logic                      reset,

    // AFU write beats
    input  logic                      afu_wr_valid,
    input  logic                      afu_wr_sop,
    input  cl_addr_t                  afu_wr_addr,
    input  cl_num_t                   afu_wr_len,
    input  mdata_t                    afu_wr_mdata,
    input  cl_data_t                  afu_wr_data,
    output logic                      afu_wr_almost_full,

    // Write data into the heap
    output logic                      heap_wen,
    output logic [HEAP_ADDR_BITS-1:0] heap_waddr,
    output cl_data_t                  heap_wdata,

    // One header per packet toward the FIU edge
    output logic                      hdr_valid,
    output cl_addr_t                  hdr_addr,
    output cl_num_t                   hdr_len,
    output mdata_t                    hdr_mdata,
    output logic [IDX_BITS-1:0]       hdr_idx,
    input  logic                      hdr_almost_full,

    // Slot release from the FIU edge
    input  logic                      free_en,
    input  logic [IDX_BITS-1:0]       free_idx
);

    afu_edge_state_t           state;
    logic [N_HEAP_ENTRIES-1:0] free_slots;
    logic [N_HEAP_ENTRIES-1:0] free_slots_next;
    logic [IDX_BITS-1:0]       alloc_idx;
    logic [IDX_BITS-1:0]       cur_idx;
    logic [IDX_BITS-1:0]       slot;
    cl_num_t                   beat_cnt;
    cl_num_t                   beat_num;
    cl_addr_t                  pkt_addr;
    cl_num_t                   pkt_len;
    mdata_t                    pkt_mdata;
    logic                      last_beat;

    // Lowest free slot wins, scanning from the top so bit 0 is written last
    always_comb
    begin
        alloc_idx = '0;
        for (int i = N_HEAP_ENTRIES - 1; i >= 0; i--)
        begin
            if (free_slots[i])
                alloc_idx = IDX_BITS'(i);
        end
    end

    always_comb
    begin
        // A sop beat opens a new slot at beat 0, later beats reuse it
        slot = afu_wr_sop ? alloc_idx : cur_idx;
        beat_num = afu_wr_sop ? cl_num_t'(0) : beat_cnt;
        last_beat = afu_wr_valid &&
                    (afu_wr_sop ? (afu_wr_len == '0) : (beat_cnt == pkt_len));

        // Allocation and release never touch the same slot in one cycle
        free_slots_next = free_slots;
        if (afu_wr_valid && afu_wr_sop)
            free_slots_next[alloc_idx] = 1'b0;
        if (free_en)
            free_slots_next[free_idx] = 1'b1;
    end

    // wait_slot is entered exactly when the heap has run out of slots
    assign afu_wr_almost_full = (state == st_wait_slot) || hdr_almost_full;

    // ========================================
    // Control state
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_idle;
            free_slots <= '1;
            beat_cnt <= '0;
            heap_wen <= 1'b0;
            hdr_valid <= 1'b0;
        end
        else
        begin
            free_slots <= free_slots_next;
            heap_wen <= afu_wr_valid;
            hdr_valid <= last_beat;
            if (afu_wr_valid)
                beat_cnt <= beat_num + 1'b1;

            unique case (state)
                st_wait_slot:
                begin
                    // A release from the FIU edge lets new packets in again
                    if (|free_slots)
                        state <= st_idle;
                end
                default:
                begin
                    if (last_beat)
                        state <= (|free_slots_next) ? st_idle : st_wait_slot;
                    else if (afu_wr_valid)
                        state <= st_beats;
                end
            endcase
        end
    end

    // ========================================
    // Packet payload, heap write and header
    // ========================================

    always_ff @(posedge clk)
    begin
        if (afu_wr_valid && afu_wr_sop)
        begin
            cur_idx <= alloc_idx;
            pkt_addr <= afu_wr_addr;
            pkt_len <= afu_wr_len;
            pkt_mdata <= afu_wr_mdata;
        end

        heap_waddr <= {slot, beat_num};
        heap_wdata <= afu_wr_data;

        // Single-beat packets take their fields straight from the sop beat
        hdr_addr <= afu_wr_sop ? afu_wr_addr : pkt_addr;
        hdr_len <= afu_wr_sop ? afu_wr_len : pkt_len;
        hdr_mdata <= afu_wr_sop ? afu_wr_mdata : pkt_mdata;
        hdr_idx <= slot;
    end

endmodule

/* hw/fiu_edge.sv */
module fiu_edge
    import mem_edge_pkg::*;
#(
    parameter int N_HEAP_ENTRIES = 4,
    parameter int PT_MDATA_BIT = 15,
    localparam int IDX_BITS = $clog2(N_HEAP_ENTRIES),
    localparam int HEAP_ADDR_BITS = IDX_BITS + $bits(cl_num_t)
)
(
    input  logic                      clk,
    input  logic                      reset,

    // AFU reads and their memory side
    input  logic                      afu_rd_valid,
    input  cl_addr_t                  afu_rd_addr,
    input  mdata_t                    afu_rd_mdata,
    output logic                      afu_rd_almost_full,
    output logic                      mem_rd_valid,
    output cl_addr_t                  mem_rd_addr,
    output mdata_t                    mem_rd_mdata,
    input  logic                      mem_rd_almost_full,

    // Read responses
    input  logic                      mem_rsp_valid,
    input  mdata_t                    mem_rsp_mdata,
    input  cl_data_t                  mem_rsp_data,
    output logic                      afu_rsp_valid,
    output mdata_t                    afu_rsp_mdata,
    output cl_data_t                  afu_rsp_data,

    // Page-table walker
    input  logic                      pt_read_en,
    input  cl_addr_t                  pt_read_addr,
    output logic                      pt_read_rdy,
    output logic                      pt_data_valid,
    output cl_data_t                  pt_data,

    // Write headers, heap read and memory writes
    input  logic                      hdr_valid,
    input  cl_addr_t                  hdr_addr,
    input  cl_num_t                   hdr_len,
    input  mdata_t                    hdr_mdata,
    input  logic [IDX_BITS-1:0]       hdr_idx,
    output logic                      hdr_almost_full,
    output logic [HEAP_ADDR_BITS-1:0] heap_raddr,
    input  cl_data_t                  heap_rdata,
    output logic                      mem_wr_valid,
    output logic                      mem_wr_sop,
    output cl_addr_t                  mem_wr_addr,
    output mdata_t                    mem_wr_mdata,
    output cl_data_t                  mem_wr_data,
    input  logic                      mem_wr_almost_full,
    output logic                      free_en,
    output logic [IDX_BITS-1:0]       free_idx
);

    localparam int HDR_BITS = $bits(cl_addr_t) + $bits(cl_num_t) + $bits(mdata_t) + IDX_BITS;

    // Walker reads carry only the reserved bit in their metadata
    localparam mdata_t PT_MDATA = mdata_t'(1 << PT_MDATA_BIT);

    // ========================================
    // Reads and walker injection
    // ========================================

    logic     pt_req;
    logic     pt_emit;
    cl_addr_t pt_addr;
    logic     is_pt_rsp;

    // The walker request waits for a cycle with no AFU read
    assign pt_read_rdy = !pt_req;
    assign pt_emit = pt_req && !afu_rd_valid;
    assign afu_rd_almost_full = mem_rd_almost_full || pt_req;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pt_req <= 1'b0;
            mem_rd_valid <= 1'b0;
        end
        else
        begin
            pt_req <= (pt_req && !pt_emit) || pt_read_en;
            mem_rd_valid <= afu_rd_valid || pt_emit;
        end

        if (pt_read_en)
            pt_addr <= pt_read_addr;
        mem_rd_addr <= afu_rd_valid ? afu_rd_addr : pt_addr;
        mem_rd_mdata <= afu_rd_valid ? afu_rd_mdata : PT_MDATA;
    end

    // Responses are steered in the same cycle by the reserved bit
    always_comb
    begin
        is_pt_rsp = mem_rsp_mdata[PT_MDATA_BIT];
        pt_data_valid = mem_rsp_valid && is_pt_rsp;
        pt_data = mem_rsp_data;
        afu_rsp_valid = mem_rsp_valid && !is_pt_rsp;
        afu_rsp_mdata = mem_rsp_mdata;
        afu_rsp_data = mem_rsp_data;
    end

    // ========================================
    // Write expansion
    // ========================================

    logic [HDR_BITS-1:0] hdr_first;
    logic                hdr_not_empty;
    logic                hdr_deq;
    cl_addr_t            first_addr;
    cl_num_t             first_len;
    mdata_t              first_mdata;
    logic [IDX_BITS-1:0] first_idx;

    req_fifo #(
        .N_DATA_BITS(HDR_BITS),
        .N_ENTRIES(WR_ALMOST_FULL_THRESHOLD + 2)
    ) hdr_fifo (
        .clk(clk),
        .reset(reset),
        .enq_en(hdr_valid),
        .enq_data({hdr_addr, hdr_len, hdr_mdata, hdr_idx}),
        .almost_full(hdr_almost_full),
        .first(hdr_first),
        .deq_en(hdr_deq),
        .not_empty(hdr_not_empty)
    );

    assign {first_addr, first_len, first_mdata, first_idx} = hdr_first;

    // Stage 1 holds the packet being expanded and selects one beat
    logic                stg1_valid;
    cl_addr_t            stg1_addr;
    cl_num_t             stg1_len;
    mdata_t              stg1_mdata;
    logic [IDX_BITS-1:0] stg1_idx;
    cl_num_t             stg1_beat;
    logic                stg1_done;
    logic                may_fire;

    // Stage 2 waits for the registered heap read
    logic                stg2_valid;
    logic                stg2_sop;
    cl_addr_t            stg2_addr;
    mdata_t              stg2_mdata;

    always_comb
    begin
        may_fire = !mem_wr_almost_full;
        stg1_done = may_fire && stg1_valid && (stg1_beat == stg1_len);
        hdr_deq = hdr_not_empty && (!stg1_valid || stg1_done);
        heap_raddr = {stg1_idx, stg1_beat};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stg1_valid <= 1'b0;
            stg2_valid <= 1'b0;
            mem_wr_valid <= 1'b0;
            free_en <= 1'b0;
        end
        else
        begin
            if (hdr_deq)
                stg1_valid <= 1'b1;
            else if (stg1_done)
                stg1_valid <= 1'b0;
            stg2_valid <= may_fire && stg1_valid;
            mem_wr_valid <= stg2_valid;

            // Release the slot once its last beat has left stage 1
            free_en <= stg1_done;
        end

        if (hdr_deq)
        begin
            stg1_addr <= first_addr;
            stg1_len <= first_len;
            stg1_mdata <= first_mdata;
            stg1_idx <= first_idx;
            stg1_beat <= '0;
        end
        else if (may_fire && stg1_valid)
            stg1_beat <= stg1_beat + 1'b1;
        free_idx <= stg1_idx;

        // Packet addresses are aligned, so OR-ing in the beat steps the line
        stg2_sop <= (stg1_beat == '0);
        stg2_addr <= stg1_addr | cl_addr_t'(stg1_beat);
        stg2_mdata <= stg1_mdata;

        // Stage 3 joins the header with its heap data
        mem_wr_sop <= stg2_sop;
        mem_wr_addr <= stg2_addr;
        mem_wr_mdata <= stg2_mdata;
        mem_wr_data <= heap_rdata;
    end

endmodule

/* hw/mem_edge_top.sv */
module mem_edge_top
    import mem_edge_pkg::*;
#(
    parameter int N_HEAP_ENTRIES = 4,
    parameter int PT_MDATA_BIT = 15,
    localparam int IDX_BITS = $clog2(N_HEAP_ENTRIES),
    localparam int HEAP_ADDR_BITS = IDX_BITS + $bits(cl_num_t)
)
(
    input  logic     clk,
    input  logic     reset,

    // AFU side
    input  logic     afu_rd_valid,
    input  cl_addr_t afu_rd_addr,
    input  mdata_t   afu_rd_mdata,
    output logic     afu_rd_almost_full,
    input  logic     afu_wr_valid,
    input  logic     afu_wr_sop,
    input  cl_addr_t afu_wr_addr,
    input  cl_num_t  afu_wr_len,
    input  mdata_t   afu_wr_mdata,
    input  cl_data_t afu_wr_data,
    output logic     afu_wr_almost_full,
    output logic     afu_rsp_valid,
    output mdata_t   afu_rsp_mdata,
    output cl_data_t afu_rsp_data,

    // Memory side
    output logic     mem_rd_valid,
    output cl_addr_t mem_rd_addr,
    output mdata_t   mem_rd_mdata,
    input  logic     mem_rd_almost_full,
    output logic     mem_wr_valid,
    output logic     mem_wr_sop,
    output cl_addr_t mem_wr_addr,
    output mdata_t   mem_wr_mdata,
    output cl_data_t mem_wr_data,
    input  logic     mem_wr_almost_full,
    input  logic     mem_rsp_valid,
    input  mdata_t   mem_rsp_mdata,
    input  cl_data_t mem_rsp_data,

    // Page-table walker
    input  logic     pt_read_en,
    input  cl_addr_t pt_read_addr,
    output logic     pt_read_rdy,
    output logic     pt_data_valid,
    output cl_data_t pt_data
);

    // Heap traffic
    logic                      heap_wen;
    logic [HEAP_ADDR_BITS-1:0] heap_waddr;
    cl_data_t                  heap_wdata;
    logic [HEAP_ADDR_BITS-1:0] heap_raddr;
    cl_data_t                  heap_rdata;

    // Header queue and slot release between the two edges
    logic                      hdr_valid;
    cl_addr_t                  hdr_addr;
    cl_num_t                   hdr_len;
    mdata_t                    hdr_mdata;
    logic [IDX_BITS-1:0]       hdr_idx;
    logic                      hdr_almost_full;
    logic                      free_en;
    logic [IDX_BITS-1:0]       free_idx;

    afu_edge #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES)
    ) afu_edge_i (.*);

    // Every slot owns MAX_BEATS consecutive heap lines
    write_heap #(
        .N_ENTRIES(N_HEAP_ENTRIES * MAX_BEATS)
    ) write_heap_i (
        .clk(clk),
        .wen(heap_wen),
        .waddr(heap_waddr),
        .wdata(heap_wdata),
        .raddr(heap_raddr),
        .rdata(heap_rdata)
    );

    fiu_edge #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES),
        .PT_MDATA_BIT(PT_MDATA_BIT)
    ) fiu_edge_i (.*);

endmodule

/* verif/mem_edge_asserts.sv */
module mem_edge_asserts
#(
    parameter int PT_MDATA_BIT = 15
)
(
    input logic        clk,
    input logic        reset,
    input logic        afu_rd_valid,
    input logic [15:0] afu_rd_mdata,
    input logic        pt_read_en,
    input logic        pt_read_rdy,
    input logic        mem_rd_valid
);

    // The reserved bit belongs to the walker alone
    afu_mdata_clean: assert property (@(posedge clk) disable iff (reset)
        afu_rd_valid |-> !afu_rd_mdata[PT_MDATA_BIT])
        else $error("AFU read uses the reserved metadata bit");

    pt_en_when_rdy: assert property (@(posedge clk) disable iff (reset)
        pt_read_en |-> pt_read_rdy)
        else $error("Walker read raised while not ready");

    rd_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(mem_rd_valid))
        else $error("Memory read valid is unknown");

endmodule

bind fiu_edge mem_edge_asserts #(.PT_MDATA_BIT(PT_MDATA_BIT)) mem_edge_asserts_i (.*);

/* verif/mem_edge_tb.sv */
module mem_edge_tb
    import mem_edge_pkg::*;
;

    localparam int N_HEAP_ENTRIES = 4;
    localparam int PT_MDATA_BIT = 15;
    localparam int N_ROWS = 13;
    localparam logic [63:0] DATA_MULT = 64'h9e37_79b9_7f4a_7c15;

    // Row kinds of the stimulus table
    localparam int K_RD = 0;
    localparam int K_PT = 1;
    localparam int K_RDPT = 2;
    localparam int K_WR = 3;
    localparam int K_WRS = 4;

    logic clk, reset;
    logic afu_rd_valid, afu_rd_almost_full, afu_wr_valid, afu_wr_sop, afu_wr_almost_full;
    cl_addr_t afu_rd_addr, afu_wr_addr, mem_rd_addr, mem_wr_addr, pt_read_addr;
    mdata_t afu_rd_mdata, afu_wr_mdata, afu_rsp_mdata, mem_rd_mdata, mem_wr_mdata, mem_rsp_mdata;
    cl_num_t afu_wr_len;
    cl_data_t afu_wr_data, afu_rsp_data, mem_wr_data, mem_rsp_data, pt_data;
    logic afu_rsp_valid, mem_rd_valid, mem_rd_almost_full, mem_wr_valid, mem_wr_sop;
    logic mem_wr_almost_full, mem_rsp_valid, pt_read_en, pt_read_rdy, pt_data_valid;

    mem_edge_top #(
        .N_HEAP_ENTRIES(N_HEAP_ENTRIES),
        .PT_MDATA_BIT(PT_MDATA_BIT)
    ) mem_edge_top_i (.*);

    // ========================================
    // Stimulus table and expectation queues
    // ========================================

    int       row_kind [N_ROWS];
    cl_addr_t row_addr [N_ROWS];
    int       row_len [N_ROWS];
    mdata_t   row_mdata [N_ROWS];
    cl_data_t row_data [N_ROWS][MAX_BEATS];

    logic [31:0] rng;
    int          cyc;
    logic        stress;
    logic        pt_pend;
    int          slots_held;
    cl_addr_t    rd_addr_q[$];
    mdata_t      rd_md_q[$];
    int          rd_cyc_q[$];
    mdata_t      rsp_md_q[$];
    cl_data_t    rsp_data_q[$];
    cl_data_t    pt_data_q[$];
    logic        wr_sop_q[$];
    logic        wr_last_q[$];
    cl_addr_t    wr_addr_q[$];
    mdata_t      wr_md_q[$];
    cl_data_t    wr_data_q[$];
    logic        d1_v, d2_v;
    cl_addr_t    d1_a, d2_a;
    mdata_t      d1_m, d2_m;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            fail_run("Check failed");
        end
    endtask

    task automatic set_row(input int r, input int kind, input cl_addr_t addr,
                           input int len, input mdata_t md);
        row_kind[r] = kind;
        row_addr[r] = addr;
        row_len[r] = len;
        row_mdata[r] = md;
        for (int b = 0; b < MAX_BEATS; b++)
        begin
            rng = xorshift(rng);
            row_data[r][b][63:32] = rng;
            rng = xorshift(rng);
            row_data[r][b][31:0] = rng;
        end
    endtask

    // More stress packets than heap slots, so slots must be reused
    task automatic build_table();
        set_row(0, K_RD, 32'h100, 0, 16'h0011);
        set_row(1, K_RD, 32'h200, 3, 16'h0120);
        set_row(2, K_PT, 32'h3000, 0, 16'h0000);
        set_row(3, K_RDPT, 32'h400, 2, 16'h0230);
        set_row(4, K_WR, 32'h500, 0, 16'h0341);
        set_row(5, K_WR, 32'h540, 3, 16'h0342);
        set_row(6, K_WR, 32'h602, 1, 16'h0343);
        for (int i = 0; i < 6; i++)
            set_row(7 + i, K_WRS, 32'h700 + 32'(16 * i), (i + 1) % MAX_BEATS, 16'(16'h0400 + i));
    endtask

    // ========================================
    // Drivers
    // ========================================

    task automatic drive_reads(input int r, input bit do_rd, input bit do_pt);
        int n;
        int k;
        n = do_rd ? row_len[r] + 1 : 0;
        @(posedge clk);
        while (!pt_read_rdy)
            @(posedge clk);
        k = cyc;
        if (do_pt)
        begin
            pt_read_en <= 1'b1;
            pt_read_addr <= row_addr[r] + 32'h1000;
        end
        for (int i = 0; i < n; i++)
        begin
            // The walker strobe lasts only for the first cycle
            if (i > 0)
            begin
                @(posedge clk);
                pt_read_en <= 1'b0;
            end
            afu_rd_valid <= 1'b1;
            afu_rd_addr <= row_addr[r] + 32'(i);
            afu_rd_mdata <= row_mdata[r] + 16'(i);
            rd_addr_q.push_back(row_addr[r] + 32'(i));
            rd_md_q.push_back(row_mdata[r] + 16'(i));
            rd_cyc_q.push_back(cyc + 2);
        end
        // The walker read takes the first cycle without an AFU read
        if (do_pt)
        begin
            rd_addr_q.push_back(row_addr[r] + 32'h1000);
            rd_md_q.push_back(mdata_t'(1 << PT_MDATA_BIT));
            rd_cyc_q.push_back(k + ((n > 1) ? n : 1) + 2);
        end
        @(posedge clk);
        afu_rd_valid <= 1'b0;
        pt_read_en <= 1'b0;
    endtask

    task automatic drive_write(input int r);
        @(posedge clk);
        while (afu_wr_almost_full)
            @(posedge clk);
        // A new packet may only start while a heap slot is free
        check_value("wr_slot_free", 1, slots_held < N_HEAP_ENTRIES);
        slots_held = slots_held + 1;
        for (int b = 0; b <= row_len[r]; b++)
        begin
            if (b > 0)
                @(posedge clk);
            afu_wr_valid <= 1'b1;
            afu_wr_sop <= (b == 0);
            afu_wr_addr <= row_addr[r];
            afu_wr_len <= cl_num_t'(row_len[r]);
            afu_wr_mdata <= row_mdata[r];
            afu_wr_data <= row_data[r][b];
            wr_sop_q.push_back(b == 0);
            wr_last_q.push_back(b == row_len[r]);
            wr_addr_q.push_back(row_addr[r] | 32'(b));
            wr_md_q.push_back(row_mdata[r]);
            wr_data_q.push_back(row_data[r][b]);
        end
        // One idle cycle lets almost-full reflect this packet
        @(posedge clk) afu_wr_valid <= 1'b0;
    endtask

    // ========================================
    // Clock, memory model and monitor
    // ========================================

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        d1_v <= mem_rd_valid;
        d1_a <= mem_rd_addr;
        d1_m <= mem_rd_mdata;
        d2_v <= d1_v;
        d2_a <= d1_a;
        d2_m <= d1_m;
        mem_rsp_valid <= d2_v && !reset;
        mem_rsp_mdata <= d2_m;
        mem_rsp_data <= cl_data_t'(d2_a) * DATA_MULT;
        if (stress)
        begin
            rng = xorshift(rng);
            mem_wr_almost_full <= rng[4];
        end
        else
            mem_wr_almost_full <= 1'b0;
    end

    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (mem_rd_valid)
            begin
                if (rd_addr_q.size() == 0)
                    fail_run("Memory read issued with no read expected");
                check_value("rd_addr", rd_addr_q[0], mem_rd_addr);
                check_value("rd_mdata", rd_md_q[0], mem_rd_mdata);
                check_value("rd_cycle", rd_cyc_q.pop_front(), cyc);
                if (rd_md_q[0][PT_MDATA_BIT])
                begin
                    pt_pend = 1'b0;
                    pt_data_q.push_back(cl_data_t'(rd_addr_q[0]) * DATA_MULT);
                end
                else
                begin
                    rsp_md_q.push_back(rd_md_q[0]);
                    rsp_data_q.push_back(cl_data_t'(rd_addr_q[0]) * DATA_MULT);
                end
                void'(rd_addr_q.pop_front());
                void'(rd_md_q.pop_front());
            end
            // The walker is busy from the cycle after pt_read_en until its read appears
            check_value("pt_read_rdy", !pt_pend, pt_read_rdy);
            check_value("afu_rd_almost_full", mem_rd_almost_full || pt_pend,
                        afu_rd_almost_full);
            if (pt_read_en)
                pt_pend = 1'b1;
            if (afu_rsp_valid)
            begin
                if (rsp_md_q.size() == 0)
                    fail_run("AFU response arrived with none outstanding");
                check_value("afu_rsp_mdata", rsp_md_q.pop_front(), afu_rsp_mdata);
                check_value("afu_rsp_data", rsp_data_q.pop_front(), afu_rsp_data);
            end
            if (pt_data_valid)
            begin
                if (pt_data_q.size() == 0)
                    fail_run("Walker data arrived with no walker read outstanding");
                check_value("pt_data", pt_data_q.pop_front(), pt_data);
            end
            if (mem_wr_valid)
            begin
                if (wr_addr_q.size() == 0)
                    fail_run("Memory write issued with no beat expected");
                // The slot of a packet is free again once its last beat is out
                if (wr_last_q.pop_front())
                    slots_held = slots_held - 1;
                check_value("wr_sop", wr_sop_q.pop_front(), mem_wr_sop);
                check_value("wr_addr", wr_addr_q.pop_front(), mem_wr_addr);
                check_value("wr_mdata", wr_md_q.pop_front(), mem_wr_mdata);
                check_value("wr_data", wr_data_q.pop_front(), mem_wr_data);
            end
        end
    end

    // Watchdog sized from the table length
    initial
    begin
        repeat (N_ROWS * 200 + 20) @(posedge clk);
        fail_run("Timeout waiting for outstanding traffic");
    end

    // ========================================
    // Main sequence
    // ========================================

    initial
    begin
        rng = 32'hefb3_d71b;
        cyc = 0;
        stress = 1'b0;
        pt_pend = 1'b0;
        slots_held = 0;
        reset = 1'b1;
        afu_rd_valid = 1'b0;
        afu_rd_addr = '0;
        afu_rd_mdata = '0;
        afu_wr_valid = 1'b0;
        afu_wr_sop = 1'b0;
        afu_wr_addr = '0;
        afu_wr_len = '0;
        afu_wr_mdata = '0;
        afu_wr_data = '0;
        mem_rd_almost_full = 1'b0;
        mem_wr_almost_full = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_mdata = '0;
        mem_rsp_data = '0;
        pt_read_en = 1'b0;
        pt_read_addr = '0;
        build_table();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        for (int r = 0; r < N_ROWS; r++)
        begin
            stress <= (row_kind[r] == K_WRS);
            case (row_kind[r])
                K_RD: drive_reads(r, 1'b1, 1'b0);
                K_PT: drive_reads(r, 1'b0, 1'b1);
                K_RDPT: drive_reads(r, 1'b1, 1'b1);
                default: drive_write(r);
            endcase
            repeat (2) @(posedge clk);
        end
        stress <= 1'b0;
        while (rd_addr_q.size() + rsp_md_q.size() + pt_data_q.size() + wr_addr_q.size() != 0)
            @(posedge clk);
        repeat (10) @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* all.f */
hw/mem_edge_pkg.sv
hw/write_heap.sv
hw/req_fifo.sv
hw/afu_edge.sv
hw/fiu_edge.sv
hw/mem_edge_top.sv
verif/mem_edge_asserts.sv
verif/mem_edge_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_edge_tb
FILELIST  ?= all.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
